/* Makefile */
# Verilator build and run of the core testbench
VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Test failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
rtl/core_cfg_pkg.sv
rtl/isa_pkg.sv
rtl/fetch_unit.sv
rtl/instr_decode.sv
rtl/exec_unit.sv
rtl/writeback.sv
rtl/cpu_top.sv
testbench/cpu_top_sva.sv
testbench/tb_cpu_top.sv

/* rtl/core_cfg_pkg.sv */
package core_cfg_pkg;

    // Data path and address width
    localparam int XLEN   = 32;

    // General purpose register file
    localparam int NREGS  = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1c000000;

    // Instruction queue between fetch and execute
    localparam int IQ_DEPTH = 2;
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
    localparam int IQ_CNT_W = $clog2(IQ_DEPTH + 1);

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_idx_t;

endpackage

/* rtl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top
    import core_cfg_pkg::*;
    import isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,

    // Instruction memory port
    output logic       inst_req_o,
    output word_t      inst_addr_o,
    input  logic       inst_valid_i,
    input  word_t      inst_data_i,

    // Commit trace
    output logic       debug_wb_valid_o,
    output word_t      debug_wb_pc_o,
    output logic [3:0] debug_wb_rf_wen_o,
    output reg_idx_t   debug_wb_rf_wnum_o,
    output word_t      debug_wb_rf_wdata_o
);

    // Fetch <-> execute
    logic     iq_valid;
    word_t    iq_pc;
    word_t    iq_instr;
    logic     iq_pop;
    logic     redirect;
    word_t    redirect_pc;

    // Decode outputs
    alu_op_e  op;
    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk_or_rd;
    word_t    imm;
    logic     writes_rd;

    // Register file
    word_t    rdata_a;
    word_t    rdata_b;
    logic     wb_en;
    word_t    wb_pc;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     wb_we;

    fetch_unit u_fetch (
        .clk         (clk),
        .rst_i       (rst_i),
        .inst_req_o  (inst_req_o),
        .inst_addr_o (inst_addr_o),
        .inst_valid_i(inst_valid_i),
        .inst_data_i (inst_data_i),
        .iq_valid    (iq_valid),
        .iq_pc       (iq_pc),
        .iq_instr    (iq_instr),
        .iq_pop      (iq_pop),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    instr_decode u_decode (
        .iq_instr (iq_instr),
        .op       (op),
        .rd       (rd),
        .rj       (rj),
        .rk_or_rd (rk_or_rd),
        .imm      (imm),
        .writes_rd(writes_rd)
    );

    exec_unit u_exec (
        .iq_valid   (iq_valid),
        .iq_pc      (iq_pc),
        .op         (op),
        .rd         (rd),
        .imm        (imm),
        .writes_rd  (writes_rd),
        .iq_pop     (iq_pop),
        .rdata_a    (rdata_a),
        .rdata_b    (rdata_b),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .wb_en      (wb_en),
        .wb_pc      (wb_pc),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .wb_we      (wb_we)
    );

    writeback u_wb (
        .clk                (clk),
        .rst_i              (rst_i),
        .rj                 (rj),
        .rk_or_rd           (rk_or_rd),
        .rdata_a            (rdata_a),
        .rdata_b            (rdata_b),
        .wb_en              (wb_en),
        .wb_pc              (wb_pc),
        .wb_rd              (wb_rd),
        .wb_data            (wb_data),
        .wb_we              (wb_we),
        .debug_wb_valid_o   (debug_wb_valid_o),
        .debug_wb_pc_o      (debug_wb_pc_o),
        .debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

endmodule

/* rtl/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit
    import core_cfg_pkg::*;
    import isa_pkg::*;
(
    // Queue head and its decoded fields
    input  logic     iq_valid,
    input  word_t    iq_pc,
    input  alu_op_e  op,
    input  reg_idx_t rd,
    input  word_t    imm,
    input  logic     writes_rd,
    output logic     iq_pop,

    // Source operands
    input  word_t    rdata_a,
    input  word_t    rdata_b,

    // Branch redirect to fetch
    output logic     redirect,
    output word_t    redirect_pc,

    // Register write and commit
    output logic     wb_en,
    output word_t    wb_pc,
    output reg_idx_t wb_rd,
    output word_t    wb_data,
    output logic     wb_we
);

    word_t opnd_b;
    word_t alu_res;
    logic  taken;

    // One of the two is always zero for ALU operations
    assign opnd_b = rdata_b | imm;

    always_comb begin
        case (op)
            ALU_ADD: alu_res = rdata_a + opnd_b;
            ALU_SUB: alu_res = rdata_a - opnd_b;
            ALU_OR:  alu_res = rdata_a | opnd_b;
            ALU_LUI: alu_res = imm;
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        case (op)
            ALU_BEQ: taken = (rdata_a == rdata_b);
            ALU_BNE: taken = (rdata_a != rdata_b);
            default: taken = 1'b0;
        endcase
    end

    // Head executes in the cycle it is valid
    assign iq_pop      = iq_valid;

    assign redirect    = iq_valid && taken;
    assign redirect_pc = iq_pc + imm;

    // Every executed instruction commits, branches and unknown words included
    assign wb_en   = iq_valid;
    assign wb_pc   = iq_pc;
    assign wb_rd   = rd;
    assign wb_data = alu_res;
    assign wb_we   = writes_rd;

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
    import core_cfg_pkg::*;
(
    input  logic  clk,
    input  logic  rst_i,

    // Instruction port
    output logic  inst_req_o,
    output word_t inst_addr_o,
    input  logic  inst_valid_i,
    input  word_t inst_data_i,

    // Queue head towards decode
    output logic  iq_valid,
    output word_t iq_pc,
    output word_t iq_instr,
    input  logic  iq_pop,

    // Taken branch from execute
    input  logic  redirect,
    input  word_t redirect_pc
);

    word_t fetch_pc_q;
    word_t req_addr_q;
    logic  req_q;
    logic  stale_q;

    word_t q_pc    [IQ_DEPTH];
    word_t q_instr [IQ_DEPTH];
    logic [IQ_PTR_W-1:0] head_q;
    logic [IQ_PTR_W-1:0] tail;
    logic [IQ_CNT_W-1:0] count_q;
    logic [IQ_CNT_W-1:0] count_n;

    logic  resp;
    logic  waiting;
    logic  push;
    logic  pop;
    logic  issue;
    word_t next_pc;

    assign resp    = req_q && inst_valid_i;
    assign waiting = req_q && !inst_valid_i;
    // A response in the redirect cycle belongs to the old path as well
    assign push    = resp && !stale_q && !redirect;
    assign pop     = iq_pop && iq_valid;
    assign tail    = head_q + count_q[IQ_PTR_W-1:0];
    assign next_pc = redirect ? redirect_pc : fetch_pc_q;

    always_comb begin
        if (redirect) begin
            count_n = '0;
        end else begin
            count_n = count_q + IQ_CNT_W'(push) - IQ_CNT_W'(pop);
        end
    end

    // Room must cover the queue plus the request about to go out
    assign issue = !waiting && (count_n < IQ_CNT_W'(IQ_DEPTH));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            req_q      <= 1'b0;
            stale_q    <= 1'b0;
            fetch_pc_q <= RESET_PC;
            head_q     <= '0;
            count_q    <= '0;
        end else begin
            count_q <= count_n;
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            if (issue) begin
                req_q      <= 1'b1;
                fetch_pc_q <= next_pc + XLEN'(4);
            end else begin
                req_q      <= waiting;
                fetch_pc_q <= next_pc;
            end
            // Old request still in flight, its word is thrown away
            if (redirect && waiting) begin
                stale_q <= 1'b1;
            end else if (resp) begin
                stale_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr_q <= next_pc;
        end
        if (push) begin
            q_pc[tail]    <= req_addr_q;
            q_instr[tail] <= inst_data_i;
        end
    end

    assign inst_req_o  = req_q;
    assign inst_addr_o = req_addr_q;
    assign iq_valid    = (count_q != '0);
    assign iq_pc       = q_pc[head_q];
    assign iq_instr    = q_instr[head_q];

endmodule

/* rtl/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode
    import core_cfg_pkg::*;
    import isa_pkg::*;
(
    input  word_t    iq_instr,
    output alu_op_e  op,
    output reg_idx_t rd,
    output reg_idx_t rj,
    output reg_idx_t rk_or_rd,
    output word_t    imm,
    output logic     writes_rd
);

    instr_u ins;

    assign ins = iq_instr;

    // Immediate forms read r0 as second source and 3R forms carry a zero
    // immediate, so execute can merge both into one operand
    always_comb begin
        op       = ALU_NOP;
        // rd and rj sit at the same bits in every format
        rd       = ins.fmt_3r.rd;
        rj       = ins.fmt_3r.rj;
        rk_or_rd = ins.fmt_3r.rk;
        imm      = '0;

        if (ins.fmt_3r.opcode == OP_ADD_W) begin
            op = ALU_ADD;
        end else if (ins.fmt_3r.opcode == OP_SUB_W) begin
            op = ALU_SUB;
        end else if (ins.fmt_3r.opcode == OP_OR) begin
            op = ALU_OR;
        end else if (ins.fmt_2ri12.opcode == OP_ADDI_W) begin
            op       = ALU_ADD;
            rk_or_rd = '0;
            imm      = {{20{ins.fmt_2ri12.imm12[11]}}, ins.fmt_2ri12.imm12};
        end else if (ins.fmt_2ri12.opcode == OP_ORI) begin
            op       = ALU_OR;
            rk_or_rd = '0;
            // Logical immediate is zero extended
            imm      = {20'b0, ins.fmt_2ri12.imm12};
        end else if (ins.fmt_1ri20.opcode == OP_LU12I_W) begin
            op       = ALU_LUI;
            rj       = '0;
            rk_or_rd = '0;
            imm      = {ins.fmt_1ri20.imm20, 12'b0};
        end else if (ins.fmt_2ri16.opcode == OP_BEQ ||
                     ins.fmt_2ri16.opcode == OP_BNE) begin
            op       = (ins.fmt_2ri16.opcode == OP_BEQ) ? ALU_BEQ : ALU_BNE;
            // Branches compare rj against rd
            rk_or_rd = ins.fmt_2ri16.rd;
            imm      = {{14{ins.fmt_2ri16.offs16[15]}}, ins.fmt_2ri16.offs16, 2'b00};
        end
    end

    // r0 is hardwired, so a write to it never reaches the file
    assign writes_rd = (op inside {ALU_ADD, ALU_SUB, ALU_OR, ALU_LUI}) && (rd != '0);

endmodule

/* rtl/isa_pkg.sv */
package isa_pkg;
    import core_cfg_pkg::*;

    // Register-register form, e.g. add.w rd, rj, rk
    typedef struct packed {
        logic [16:0] opcode;
        reg_idx_t    rk;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_3r_t;

    // Register plus 12-bit immediate
    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_2ri12_t;

    // Conditional branches, rj compared against rd
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } fmt_2ri16_t;

    // Upper immediate form
    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] imm20;
        reg_idx_t    rd;
    } fmt_1ri20_t;

    // One fetched word, viewed in each encoding
    typedef union packed {
        fmt_3r_t    fmt_3r;
        fmt_2ri12_t fmt_2ri12;
        fmt_2ri16_t fmt_2ri16;
        fmt_1ri20_t fmt_1ri20;
    } instr_u;

    localparam logic [16:0] OP_ADD_W   = 17'h00020;
    localparam logic [16:0] OP_SUB_W   = 17'h00022;
    localparam logic [16:0] OP_OR      = 17'h0002a;
    localparam logic [9:0]  OP_ADDI_W  = 10'h00a;
    localparam logic [9:0]  OP_ORI     = 10'h00e;
    localparam logic [6:0]  OP_LU12I_W = 7'h0a;
    localparam logic [5:0]  OP_BEQ     = 6'h16;
    localparam logic [5:0]  OP_BNE     = 6'h17;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_OR,
        ALU_LUI,
        ALU_BEQ,
        ALU_BNE,
        ALU_NOP
    } alu_op_e;

endpackage

/* rtl/writeback.sv */
`timescale 1ns/1ps

module writeback
    import core_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,

    // Read ports for decode
    input  reg_idx_t    rj,
    input  reg_idx_t    rk_or_rd,
    output word_t       rdata_a,
    output word_t       rdata_b,

    // Write from execute
    input  logic        wb_en,
    input  word_t       wb_pc,
    input  reg_idx_t    wb_rd,
    input  word_t       wb_data,
    input  logic        wb_we,

    // Commit trace
    output logic        debug_wb_valid_o,
    output word_t       debug_wb_pc_o,
    output logic [3:0]  debug_wb_rf_wen_o,
    output reg_idx_t    debug_wb_rf_wnum_o,
    output word_t       debug_wb_rf_wdata_o
);

    word_t regs [NREGS];

    logic  rf_write;

    assign rf_write = wb_en && wb_we && (wb_rd != '0);

    // Write lands at the edge, before the next head reads it
    always_ff @(posedge clk) begin
        if (rf_write) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rdata_a = (rj == '0) ? '0 : regs[rj];
    assign rdata_b = (rk_or_rd == '0) ? '0 : regs[rk_or_rd];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            debug_wb_valid_o  <= 1'b0;
            debug_wb_rf_wen_o <= 4'b0;
        end else begin
            debug_wb_valid_o  <= wb_en;
            debug_wb_rf_wen_o <= {3'b0, rf_write};
        end
    end

    always_ff @(posedge clk) begin
        if (wb_en) begin
            debug_wb_pc_o       <= wb_pc;
            debug_wb_rf_wnum_o  <= wb_rd;
            debug_wb_rf_wdata_o <= wb_data;
        end
    end

endmodule

/* testbench/cpu_top_sva.sv */
`timescale 1ns/1ps

module cpu_top_sva
    import core_cfg_pkg::*;
(
    input logic       clk,
    input logic       rst_i,
    input logic       inst_req_o,
    input word_t      inst_addr_o,
    input logic       inst_valid_i,
    input logic       debug_wb_valid_o,
    input logic [3:0] debug_wb_rf_wen_o,
    input reg_idx_t   debug_wb_rf_wnum_o
);

    int fail_count = 0;

    // Address held until the memory answers
    addr_hold: assert property (@(posedge clk) disable iff (rst_i)
        (inst_req_o && !inst_valid_i) |=> $stable(inst_addr_o))
    else begin
        fail_count++;
        $error("instruction address changed while a request was outstanding");
    end

    wen_needs_valid: assert property (@(posedge clk) disable iff (rst_i)
        (debug_wb_rf_wen_o != 4'b0) |-> debug_wb_valid_o)
    else begin
        fail_count++;
        $error("register write enable set without a commit");
    end

    // r0 is never reported as written
    wnum_nonzero: assert property (@(posedge clk) disable iff (rst_i)
        (debug_wb_rf_wen_o != 4'b0) |-> (debug_wb_rf_wnum_o != '0))
    else begin
        fail_count++;
        $error("register write reported for r0");
    end

endmodule

bind cpu_top cpu_top_sva u_sva (
    .clk               (clk),
    .rst_i             (rst_i),
    .inst_req_o        (inst_req_o),
    .inst_addr_o       (inst_addr_o),
    .inst_valid_i      (inst_valid_i),
    .debug_wb_valid_o  (debug_wb_valid_o),
    .debug_wb_rf_wen_o (debug_wb_rf_wen_o),
    .debug_wb_rf_wnum_o(debug_wb_rf_wnum_o)
);

/* testbench/tb_cpu_top.sv */
`timescale 1ns/1ps

module tb_cpu_top
    import core_cfg_pkg::*;
    import isa_pkg::*;
;

    localparam int MEM_AW         = 6;
    localparam int MEM_WORDS      = 64;
    localparam int CW             = 73;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int ALU_N          = 10;

    logic       clk;
    logic       rst_i        = 1'b1;
    logic       inst_valid_i = 1'b0;
    word_t      inst_data_i  = '0;
    logic       inst_req_o;
    word_t      inst_addr_o;
    logic       debug_wb_valid_o;
    word_t      debug_wb_pc_o;
    logic [3:0] debug_wb_rf_wen_o;
    reg_idx_t   debug_wb_rf_wnum_o;
    word_t      debug_wb_rf_wdata_o;

    // Memory model state
    word_t mem [MEM_WORDS];
    int    seed      = 32'h8258cd3b;
    logic  rand_lat  = 1'b0;
    int    fixed_lat = 1;
    logic  busy      = 1'b0;
    int    wait_cnt  = 0;
    word_t req_addr;
    logic  first_taken = 1'b0;
    word_t first_addr;

    // Commits as {pc, wen, wnum, wdata}
    logic [CW-1:0] got [$];
    logic [CW-1:0] exp_q [$];
    logic [CW-1:0] saved [$];
    logic resp_seen     = 1'b0;
    int   early_commits = 0;
    int   err_count     = 0;
    int   tests_run     = 0;
    int   tests_failed  = 0;

    cpu_top uut (
        .clk                (clk),
        .rst_i              (rst_i),
        .inst_req_o         (inst_req_o),
        .inst_addr_o        (inst_addr_o),
        .inst_valid_i       (inst_valid_i),
        .inst_data_i        (inst_data_i),
        .debug_wb_valid_o   (debug_wb_valid_o),
        .debug_wb_pc_o      (debug_wb_pc_o),
        .debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t fill_word(input word_t addr);
        return addr ^ 32'hfc00_0000;
    endfunction

    function automatic word_t fetch_word(input word_t addr);
        word_t offs;
        offs = addr - RESET_PC;
        if (offs < 32'(MEM_WORDS * 4) && addr[1:0] == 2'b00) begin
            return mem[offs[MEM_AW+1:2]];
        end
        return fill_word(addr);
    endfunction

    // Unwritten commits carry only pc
    function automatic logic [CW-1:0] commit_entry(input word_t pc, input logic [3:0] wen,
                                                   input reg_idx_t wnum, input word_t wdata);
        if (wen == 4'b0) begin
            return {pc, 4'b0, 5'b0, 32'b0};
        end
        return {pc, wen, wnum, wdata};
    endfunction

    function automatic int total_errors();
        return err_count + early_commits + uut.u_sva.fail_count;
    endfunction

    function automatic word_t r3_form(input logic [16:0] op, input reg_idx_t rd,
                                      input reg_idx_t rj, input reg_idx_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic word_t ri12_form(input logic [9:0] op, input reg_idx_t rd,
                                        input reg_idx_t rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic word_t lu12i_form(input reg_idx_t rd, input logic [19:0] imm);
        return {OP_LU12I_W, imm, rd};
    endfunction

    function automatic word_t branch_form(input logic [5:0] op, input reg_idx_t rj,
                                          input reg_idx_t rd, input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    // Memory answers one request at a time after fixed or random latency
    always @(posedge clk) begin
        if (rst_i) begin
            inst_valid_i <= 1'b0;
            busy = 1'b0;
            first_taken = 1'b0;
        end else if (inst_valid_i) begin
            inst_valid_i <= 1'b0;
            busy = 1'b0;
        end else begin
            if (!busy && inst_req_o) begin
                req_addr = inst_addr_o;
                if (!first_taken) begin
                    first_addr  = inst_addr_o;
                    first_taken = 1'b1;
                end
                if (rand_lat) begin
                    wait_cnt = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
                end else begin
                    wait_cnt = fixed_lat;
                end
                busy = 1'b1;
            end
            if (busy) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    inst_valid_i <= 1'b1;
                    inst_data_i  <= fetch_word(req_addr);
                end
            end
        end
    end

    // Commit monitor
    always @(posedge clk) begin
        if (rst_i) begin
            resp_seen = 1'b0;
            got.delete();
        end else begin
            if (debug_wb_valid_o) begin
                if (!resp_seen) begin
                    $display("[ERROR] %0t commit at pc %h before any instruction response",
                             $time, debug_wb_pc_o);
                    early_commits++;
                end
                got.push_back(commit_entry(debug_wb_pc_o, debug_wb_rf_wen_o,
                                           debug_wb_rf_wnum_o, debug_wb_rf_wdata_o));
            end
            if (inst_valid_i) begin
                resp_seen = 1'b1;
            end
        end
    end

    task automatic clear_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i[MEM_AW-1:0]] = fill_word(RESET_PC + 4 * i);
        end
    endtask

    task automatic put_word(input int idx, input word_t w);
        mem[idx[MEM_AW-1:0]] = w;
    endtask

    // Reference interpreter for the first n commits
    task automatic build_expected(input int n);
        word_t    rf [NREGS];
        word_t    pc;
        word_t    w;
        word_t    res;
        word_t    next_pc;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        logic     wr;
        exp_q.delete();
        for (int i = 0; i < NREGS; i++) begin
            rf[i] = '0;
        end
        pc = RESET_PC;
        for (int c = 0; c < n; c++) begin
            w       = fetch_word(pc);
            rd      = w[4:0];
            rj      = w[9:5];
            rk      = w[14:10];
            wr      = 1'b1;
            res     = '0;
            next_pc = pc + 4;
            if (w[31:15] == OP_ADD_W) begin
                res = rf[rj] + rf[rk];
            end else if (w[31:15] == OP_SUB_W) begin
                res = rf[rj] - rf[rk];
            end else if (w[31:15] == OP_OR) begin
                res = rf[rj] | rf[rk];
            end else if (w[31:22] == OP_ADDI_W) begin
                res = rf[rj] + {{20{w[21]}}, w[21:10]};
            end else if (w[31:22] == OP_ORI) begin
                res = rf[rj] | {20'b0, w[21:10]};
            end else if (w[31:25] == OP_LU12I_W) begin
                res = {w[24:5], 12'b0};
            end else begin
                wr = 1'b0;
                if ((w[31:26] == OP_BEQ && rf[rj] == rf[rd]) ||
                    (w[31:26] == OP_BNE && rf[rj] != rf[rd])) begin
                    next_pc = pc + {{14{w[25]}}, w[25:10], 2'b00};
                end
            end
            if (wr && rd != '0) begin
                rf[rd] = res;
                exp_q.push_back(commit_entry(pc, 4'b0001, rd, res));
            end else begin
                exp_q.push_back(commit_entry(pc, 4'b0000, rd, res));
            end
            pc = next_pc;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_i <= 1'b1;
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
    endtask

    task automatic run_program(input int n);
        int waited;
        build_expected(n);
        apply_reset();
        waited = 0;
        while (got.size() < n && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (got.size() < n) begin
            $display("Timed out after %0d cycles with %0d of %0d commits seen",
                     waited, got.size(), n);
            err_count++;
        end
        if (!first_taken || first_addr !== RESET_PC) begin
            $display("[ERROR] %0t first fetch address %h, expected %h",
                     $time, first_addr, RESET_PC);
            err_count++;
        end
        for (int i = 0; i < n && i < got.size(); i++) begin
            if (got[i] !== exp_q[i]) begin
                // Fields shown as pc/wen/wnum/wdata
                $display("[ERROR] %0t commit %0d got %h/%h/%0d/%h expected %h/%h/%0d/%h",
                         $time, i, got[i][72:41], got[i][40:37], got[i][36:32],
                         got[i][31:0], exp_q[i][72:41], exp_q[i][40:37],
                         exp_q[i][36:32], exp_q[i][31:0]);
                err_count++;
            end
        end
    endtask

    task automatic close_test(input string name, input int errs_before);
        tests_run++;
        if (total_errors() != errs_before) begin
            tests_failed++;
            $display("%s: FAILED", name);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    task automatic load_alu_program();
        clear_memory();
        put_word(0, lu12i_form(5'd1, 20'h12345));
        put_word(1, ri12_form(OP_ORI, 5'd1, 5'd1, 12'h678));
        put_word(2, ri12_form(OP_ADDI_W, 5'd2, 5'd1, 12'hff0));
        put_word(3, r3_form(OP_ADD_W, 5'd3, 5'd1, 5'd2));
        put_word(4, r3_form(OP_SUB_W, 5'd4, 5'd3, 5'd1));
        put_word(5, r3_form(OP_OR, 5'd5, 5'd4, 5'd3));
        put_word(6, ri12_form(OP_ADDI_W, 5'd6, 5'd0, 12'hfff));
        put_word(7, ri12_form(OP_ORI, 5'd7, 5'd0, 12'h800));
        put_word(8, branch_form(OP_BEQ, 5'd0, 5'd0, 16'h0000));
    endtask

    task automatic first_fetch();
        int errs;
        errs = total_errors();
        clear_memory();
        put_word(0, lu12i_form(5'd1, 20'habcde));
        put_word(1, ri12_form(OP_ADDI_W, 5'd2, 5'd1, 12'h001));
        put_word(2, branch_form(OP_BEQ, 5'd0, 5'd0, 16'h0000));
        rand_lat  = 1'b0;
        fixed_lat = 3;
        run_program(4);
        close_test("first_fetch", errs);
    endtask

    task automatic alu_chain();
        int errs;
        errs = total_errors();
        load_alu_program();
        rand_lat  = 1'b0;
        fixed_lat = 1;
        run_program(ALU_N);
        saved.delete();
        for (int i = 0; i < ALU_N && i < got.size(); i++) begin
            saved.push_back(got[i]);
        end
        close_test("alu_chain", errs);
    endtask

    task automatic r0_discard();
        int errs;
        errs = total_errors();
        clear_memory();
        put_word(0, ri12_form(OP_ADDI_W, 5'd0, 5'd0, 12'h005));
        put_word(1, lu12i_form(5'd0, 20'hfffff));
        put_word(2, r3_form(OP_ADD_W, 5'd8, 5'd0, 5'd0));
        put_word(3, ri12_form(OP_ORI, 5'd9, 5'd0, 12'h007));
        put_word(4, r3_form(OP_OR, 5'd10, 5'd9, 5'd0));
        put_word(5, branch_form(OP_BEQ, 5'd0, 5'd0, 16'h0000));
        rand_lat  = 1'b0;
        fixed_lat = 1;
        run_program(7);
        close_test("r0_discard", errs);
    endtask

    task automatic branch_flow();
        int errs;
        errs = total_errors();
        clear_memory();
        put_word(0, ri12_form(OP_ADDI_W, 5'd1, 5'd0, 12'h003));
        put_word(1, ri12_form(OP_ADDI_W, 5'd2, 5'd0, 12'h003));
        put_word(2, branch_form(OP_BNE, 5'd1, 5'd2, 16'd3));
        put_word(3, branch_form(OP_BEQ, 5'd1, 5'd2, 16'd3));
        put_word(4, ri12_form(OP_ADDI_W, 5'd10, 5'd0, 12'h001));
        put_word(5, ri12_form(OP_ADDI_W, 5'd10, 5'd0, 12'h002));
        put_word(6, ri12_form(OP_ADDI_W, 5'd11, 5'd0, 12'h004));
        put_word(7, branch_form(OP_BNE, 5'd11, 5'd1, 16'd2));
        put_word(8, ri12_form(OP_ADDI_W, 5'd10, 5'd0, 12'h003));
        put_word(9, r3_form(OP_ADD_W, 5'd12, 5'd11, 5'd1));
        put_word(10, branch_form(OP_BEQ, 5'd0, 5'd0, 16'h0000));
        rand_lat  = 1'b0;
        fixed_lat = 2;
        run_program(9);
        close_test("branch_flow", errs);
    endtask

    task automatic unknown_word();
        int errs;
        errs = total_errors();
        clear_memory();
        put_word(0, 32'hffff_ffff);
        put_word(1, 32'h0000_0000);
        put_word(2, ri12_form(OP_ORI, 5'd13, 5'd0, 12'h055));
        put_word(3, branch_form(OP_BEQ, 5'd0, 5'd0, 16'h0000));
        rand_lat  = 1'b0;
        fixed_lat = 1;
        run_program(5);
        close_test("unknown_word", errs);
    endtask

    task automatic random_latency();
        int errs;
        errs = total_errors();
        load_alu_program();
        rand_lat = 1'b1;
        run_program(ALU_N);
        for (int i = 0; i < saved.size() && i < got.size(); i++) begin
            if (got[i] !== saved[i]) begin
                $display("[ERROR] %0t commit %0d differs from the fixed latency run",
                         $time, i);
                err_count++;
            end
        end
        close_test("random_latency", errs);
    endtask

    initial begin
        first_fetch();
        alu_chain();
        r0_discard();
        branch_flow();
        unknown_word();
        random_latency();
        $display("%0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
